// ==== verilog/systolic_pkg.sv ====
// ====================
// Shared definitions for the SPI matrix-multiply accelerator
// ====================

`default_nettype none

package systolic_pkg;

    // Element and result widths
    localparam int a_w   = 16;
    localparam int b_w   = 8;
    localparam int acc_w = 32;

    // Command bytes
    localparam logic [7:0] cmd_load_a   = 8'h10;
    localparam logic [7:0] cmd_load_b   = 8'h20;
    localparam logic [7:0] cmd_start    = 8'h30;
    localparam logic [7:0] cmd_read_res = 8'h40;
    localparam logic [7:0] cmd_status   = 8'h50;

    // Status byte bit positions
    localparam int stat_busy = 0;
    localparam int stat_done = 3;

    // One result, as a sum or as bytes (byte 0 is the LSB)
    typedef union packed {
        logic [acc_w-1:0]  word;
        logic [3:0][7:0]   bytes;
    } result_word_u;

endpackage

`default_nettype wire

// ==== verilog/spi_target.sv ====
// ====================
// Mode-0 SPI target on the system clock
// ====================

`timescale 1ns/1ns
`default_nettype none

module spi_target (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sclk,
    input  logic       cs_n,
    input  logic       mosi,
    output logic       miso,
    output logic [7:0] rx_data,
    output logic       rx_valid,
    input  logic [7:0] tx_data,
    input  logic       tx_ready,
    output logic       tx_done,
    output logic       cs_active
);

    logic [1:0] sclk_s;
    logic [1:0] cs_n_s;
    logic [1:0] mosi_s;
    logic       sclk_d;
    logic       cs_d;
    logic [2:0] bit_cnt;
    logic [7:0] rx_shift;
    logic [7:0] tx_shift;
    logic       tx_loaded;
    logic       sclk_rise;
    logic       sclk_fall;
    logic       slot_start;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sclk_s <= 2'b00;
            cs_n_s <= 2'b11;
            mosi_s <= 2'b00;
            sclk_d <= 1'b0;
            cs_d   <= 1'b0;
        end else begin
            sclk_s <= {sclk_s[0], sclk};
            cs_n_s <= {cs_n_s[0], cs_n};
            mosi_s <= {mosi_s[0], mosi};
            sclk_d <= sclk_s[1];
            cs_d   <= cs_active;
        end
    end

    assign cs_active = ~cs_n_s[1];
    assign sclk_rise = sclk_s[1] & ~sclk_d;
    assign sclk_fall = ~sclk_s[1] & sclk_d;

    // A slot opens on select, or on the falling edge after a full byte
    assign slot_start = (cs_active & ~cs_d) | (cs_active & sclk_fall & (bit_cnt == 3'd0));

    assign miso = tx_shift[7];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt   <= 3'd0;
            rx_shift  <= 8'h00;
            rx_data   <= 8'h00;
            rx_valid  <= 1'b0;
            tx_shift  <= 8'h00;
            tx_loaded <= 1'b0;
            tx_done   <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            tx_done  <= 1'b0;
            if (!cs_active) begin
                bit_cnt   <= 3'd0;
                tx_loaded <= 1'b0;
                tx_shift  <= 8'h00;
            end else begin
                if (sclk_rise) begin
                    rx_shift <= {rx_shift[6:0], mosi_s[1]};
                    bit_cnt  <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) begin
                        rx_data   <= {rx_shift[6:0], mosi_s[1]};
                        rx_valid  <= 1'b1;
                        tx_done   <= tx_loaded;
                        tx_loaded <= 1'b0;
                    end
                end
                // Filler byte when the controller has nothing ready
                if (slot_start) begin
                    tx_shift  <= tx_ready ? tx_data : 8'h00;
                    tx_loaded <= tx_ready;
                end else if (sclk_fall && bit_cnt != 3'd0) begin
                    tx_shift <= {tx_shift[6:0], 1'b0};
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mac_pe.sv ====
// ====================
// Systolic processing element, multiply and accumulate
// ====================

`timescale 1ns/1ns
`default_nettype none

module mac_pe (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           clear,
    input  logic [systolic_pkg::a_w-1:0]   a_in,
    input  logic [systolic_pkg::b_w-1:0]   b_in,
    output logic [systolic_pkg::a_w-1:0]   a_out,
    output logic [systolic_pkg::b_w-1:0]   b_out,
    output logic [systolic_pkg::acc_w-1:0] acc
);

    import systolic_pkg::*;

    logic [a_w+b_w-1:0] prod;

    assign prod = (a_w+b_w)'(a_in) * (a_w+b_w)'(b_in);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_out <= '0;
            b_out <= '0;
            acc   <= '0;
        end else begin
            a_out <= a_in;
            b_out <= b_in;
            if (clear) begin
                acc <= '0;
            end else begin
                acc <= acc + acc_w'(prod);
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/systolic_array.sv ====
// ====================
// Output-stationary systolic array, n x n
// Skewed operand feed, done pulse 3n cycles after start
// ====================

`timescale 1ns/1ns
`default_nettype none

module systolic_array #(
    parameter int n = 4
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               start,
    input  logic [n*n*systolic_pkg::a_w-1:0]   a_flat,
    input  logic [n*n*systolic_pkg::b_w-1:0]   b_flat,
    output logic [n*n*systolic_pkg::acc_w-1:0] c_flat,
    output logic                               done
);

    import systolic_pkg::*;

    localparam int cnt_w = $clog2(3*n + 1);

    logic             running;
    logic [cnt_w-1:0] count;
    logic [a_w-1:0]   a_left [n];
    logic [b_w-1:0]   b_top [n];
    logic [a_w-1:0]   a_bus [n][n+1];
    logic [b_w-1:0]   b_bus [n+1][n];

    // Step counter, count k is k cycles after start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            count   <= '0;
        end else if (start) begin
            running <= 1'b1;
            count   <= cnt_w'(1);
        end else if (running) begin
            if (done) begin
                running <= 1'b0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    assign done = running && (count == cnt_w'(3*n));

    // Row i and column i both lag by i steps
    always_comb begin
        int k;
        for (int i = 0; i < n; i++) begin
            k         = int'(count) - 1 - i;
            a_left[i] = '0;
            b_top[i]  = '0;
            if (running && k >= 0 && k < n) begin
                a_left[i] = a_flat[(i*n + k)*a_w +: a_w];
                b_top[i]  = b_flat[(k*n + i)*b_w +: b_w];
            end
        end
    end

    for (genvar i = 0; i < n; i++) begin : g_row
        assign a_bus[i][0] = a_left[i];
        assign b_bus[0][i] = b_top[i];
        for (genvar j = 0; j < n; j++) begin : g_col
            mac_pe u_pe (
                .clk   (clk),
                .rst_n (rst_n),
                .clear (start),
                .a_in  (a_bus[i][j]),
                .b_in  (b_bus[i][j]),
                .a_out (a_bus[i][j+1]),
                .b_out (b_bus[i+1][j]),
                .acc   (c_flat[(i*n + j)*acc_w +: acc_w])
            );
        end
    end

endmodule

`default_nettype wire

// ==== verilog/spi_command_controller.sv ====
// ====================
// Command decoder for the accelerator
// Holds A and B, launches the array, streams results back
// ====================

`timescale 1ns/1ns
`default_nettype none

module spi_command_controller #(
    parameter int n = 4
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [7:0]                           rx_data,
    input  logic                                 rx_valid,
    input  logic                                 cs_active,
    output logic [7:0]                           tx_data,
    output logic                                 tx_ready,
    input  logic                                 tx_done,
    output logic [n*n*systolic_pkg::a_w-1:0]     a_flat,
    output logic [n*n*systolic_pkg::b_w-1:0]     b_flat,
    output logic                                 start,
    input  logic                                 done,
    input  logic [n*n*systolic_pkg::acc_w-1:0]   c_flat,
    output logic                                 irq
);

    import systolic_pkg::*;

    localparam int nn    = n * n;
    localparam int idx_w = $clog2(nn);

    localparam logic [2:0] st_idle   = 3'd0;
    localparam logic [2:0] st_load_a = 3'd1;
    localparam logic [2:0] st_load_b = 3'd2;
    localparam logic [2:0] st_read   = 3'd3;
    localparam logic [2:0] st_status = 3'd4;

    logic [2:0]       state;
    logic [idx_w-1:0] elem_idx;
    logic [1:0]       byte_idx;
    logic [7:0]       lo_byte;
    logic             busy;
    logic             res_valid;
    logic             last_elem;
    logic [7:0]       status_byte;
    result_word_u     cur_res;

    assign last_elem   = (elem_idx == idx_w'(nn - 1));
    assign cur_res.word = c_flat[elem_idx*acc_w +: acc_w];

    always_comb begin
        status_byte            = 8'h00;
        status_byte[stat_busy] = busy;
        status_byte[stat_done] = res_valid;
    end

    // ====================
    // Command FSM
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            elem_idx  <= '0;
            byte_idx  <= 2'd0;
            lo_byte   <= 8'h00;
            tx_data   <= 8'h00;
            tx_ready  <= 1'b0;
            a_flat    <= '0;
            b_flat    <= '0;
            start     <= 1'b0;
            busy      <= 1'b0;
            res_valid <= 1'b0;
            irq       <= 1'b0;
        end else begin
            start <= 1'b0;
            if (done) begin
                busy      <= 1'b0;
                res_valid <= 1'b1;
                irq       <= 1'b1;
            end

            // Chip select gone mid-command
            if (!cs_active && state != st_idle) begin
                state    <= st_idle;
                tx_ready <= 1'b0;
            end else begin
                case (state)
                    st_idle: begin
                        if (rx_valid) begin
                            elem_idx <= '0;
                            byte_idx <= 2'd0;
                            case (rx_data)
                                cmd_load_a:   state <= st_load_a;
                                cmd_load_b:   state <= st_load_b;
                                cmd_read_res: state <= st_read;
                                cmd_status:   state <= st_status;
                                cmd_start: begin
                                    if (!busy) begin
                                        start     <= 1'b1;
                                        busy      <= 1'b1;
                                        irq       <= 1'b0;
                                        res_valid <= 1'b0;
                                    end
                                end
                                default:      state <= st_idle;
                            endcase
                        end
                    end

                    st_load_a: begin
                        // Element written only once both bytes are in
                        if (rx_valid) begin
                            if (!byte_idx[0]) begin
                                lo_byte  <= rx_data;
                                byte_idx <= 2'd1;
                            end else begin
                                a_flat[elem_idx*a_w +: a_w] <= {rx_data, lo_byte};
                                byte_idx <= 2'd0;
                                elem_idx <= elem_idx + 1'b1;
                                if (last_elem) begin
                                    state <= st_idle;
                                end
                            end
                        end
                    end

                    st_load_b: begin
                        if (rx_valid) begin
                            b_flat[elem_idx*b_w +: b_w] <= rx_data;
                            elem_idx <= elem_idx + 1'b1;
                            if (last_elem) begin
                                state <= st_idle;
                            end
                        end
                    end

                    st_read: begin
                        if (tx_done) begin
                            tx_ready  <= 1'b0;
                            irq       <= 1'b0;
                            res_valid <= 1'b0;
                            byte_idx  <= byte_idx + 2'd1;
                            if (byte_idx == 2'd3) begin
                                elem_idx <= elem_idx + 1'b1;
                                if (last_elem) begin
                                    state <= st_idle;
                                end
                            end
                        end else if (!tx_ready) begin
                            tx_data  <= cur_res.bytes[byte_idx];
                            tx_ready <= 1'b1;
                        end
                    end

                    st_status: begin
                        if (tx_done) begin
                            tx_ready <= 1'b0;
                            state    <= st_idle;
                        end else if (!tx_ready) begin
                            tx_data  <= status_byte;
                            tx_ready <= 1'b1;
                        end
                    end

                    default: state <= st_idle;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/systolic_spi_top.sv ====
// ====================
// Top level of the SPI matrix-multiply accelerator
// ====================

`timescale 1ns/1ns
`default_nettype none

module systolic_spi_top #(
    parameter int n = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic sclk,
    input  logic cs_n,
    input  logic mosi,
    output logic miso,
    output logic irq
);

    import systolic_pkg::*;

    logic [7:0]           rx_data;
    logic                 rx_valid;
    logic                 cs_active;
    logic [7:0]           tx_data;
    logic                 tx_ready;
    logic                 tx_done;
    logic [n*n*a_w-1:0]   a_flat;
    logic [n*n*b_w-1:0]   b_flat;
    logic [n*n*acc_w-1:0] c_flat;
    logic                 start;
    logic                 done;

    spi_target u_spi (
        .clk       (clk),
        .rst_n     (rst_n),
        .sclk      (sclk),
        .cs_n      (cs_n),
        .mosi      (mosi),
        .miso      (miso),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .tx_data   (tx_data),
        .tx_ready  (tx_ready),
        .tx_done   (tx_done),
        .cs_active (cs_active)
    );

    spi_command_controller #(.n(n)) u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .cs_active (cs_active),
        .tx_data   (tx_data),
        .tx_ready  (tx_ready),
        .tx_done   (tx_done),
        .a_flat    (a_flat),
        .b_flat    (b_flat),
        .start     (start),
        .done      (done),
        .c_flat    (c_flat),
        .irq       (irq)
    );

    systolic_array #(.n(n)) u_array (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .a_flat (a_flat),
        .b_flat (b_flat),
        .c_flat (c_flat),
        .done   (done)
    );

endmodule

`default_nettype wire

// ==== verif/systolic_spi_sva.sv ====
// ====================
// Protocol assertions on the command controller
// ====================

`timescale 1ns/1ns
`default_nettype none

module systolic_spi_sva (
    input logic clk,
    input logic rst_n,
    input logic start,
    input logic done,
    input logic tx_ready,
    input logic tx_done,
    input logic irq
);

    // Launch pulse is one cycle wide
    a_start_pulse: assert property (@(posedge clk) disable iff (!rst_n) start |=> !start)
        else $error("start held high for more than one cycle");

    a_tx_release: assert property (@(posedge clk) disable iff (!rst_n) tx_done |=> !tx_ready)
        else $error("tx_ready still high in the cycle after tx_done");

    // Interrupt only follows the array's done
    a_irq_cause: assert property (@(posedge clk) disable iff (!rst_n) $rose(irq) |-> $past(done))
        else $error("irq rose without done in the previous cycle");

endmodule

bind spi_command_controller systolic_spi_sva u_sva (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .done     (done),
    .tx_ready (tx_ready),
    .tx_done  (tx_done),
    .irq      (irq)
);

`default_nettype wire

// ==== verif/tb_systolic_spi.sv ====
// ====================
// Testbench for the SPI matrix-multiply accelerator
// Bit-banged SPI master, stimulus and results from the vectors file
// ====================

`timescale 1ns/1ns
`default_nettype none

module tb_systolic_spi;

    import systolic_pkg::*;

    localparam int n              = 4;
    localparam int nn             = n * n;
    localparam int num_tests      = 3;
    localparam int words_per_test = 3 * nn;
    // LOAD_A, LOAD_B, START, two STATUS and READ_RES, command bytes included
    localparam int bytes_per_test = (1 + 2*nn) + (1 + nn) + 1 + 2 + 2 + (1 + 4*nn);
    // Two extra runs for the aborted load and the unknown command
    localparam int timeout_ns     = (num_tests + 2) * bytes_per_test * 8 * 160 * 2;

    logic        clk;
    logic        rst_n;
    logic        sclk;
    logic        cs_n;
    logic        mosi;
    logic        miso;
    logic        irq;

    logic [31:0] vec_mem [0:num_tests*words_per_test-1];
    logic [15:0] a_src [nn];
    logic [7:0]  b_src [nn];
    logic [15:0] a_model [nn];
    logic [7:0]  b_model [nn];
    logic [31:0] c_exp [nn];
    int          errors;

    systolic_spi_top #(.n(n)) u_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .sclk  (sclk),
        .cs_n  (cs_n),
        .mosi  (mosi),
        .miso  (miso),
        .irq   (irq)
    );

    always #10 clk = ~clk;

    initial begin
        #(timeout_ns);
        $display("Timeout: the run did not finish within %0d ns", timeout_ns);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    // ====================
    // Helpers
    // ====================
    task automatic wait_clk(input int cycles);
        repeat (cycles) @(posedge clk);
        #2;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Mode 0, MSB first, 8 clk per bit
    task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
        for (int b = 7; b >= 0; b--) begin
            mosi = tx[b];
            wait_clk(4);
            rx[b] = miso;
            sclk = 1'b1;
            wait_clk(4);
            sclk = 1'b0;
        end
    endtask

    task automatic spi_select();
        cs_n = 1'b0;
        wait_clk(4);
    endtask

    task automatic spi_deselect();
        wait_clk(4);
        cs_n = 1'b1;
        wait_clk(8);
    endtask

    task automatic send_command(input logic [7:0] cmd);
        logic [7:0] rx;
        spi_select();
        spi_byte(cmd, rx);
        spi_deselect();
    endtask

    // Two zero bytes follow, which a load would store
    task automatic send_unknown(input logic [7:0] cmd);
        logic [7:0] rx;
        spi_select();
        spi_byte(cmd, rx);
        spi_byte(8'h00, rx);
        spi_byte(8'h00, rx);
        spi_deselect();
    endtask

    task automatic unpack_vector(input int t);
        int base;
        base = t * words_per_test;
        for (int e = 0; e < nn; e++) begin
            a_src[e] = vec_mem[base + e][15:0];
            b_src[e] = vec_mem[base + nn + e][7:0];
            c_exp[e] = vec_mem[base + 2*nn + e];
        end
    endtask

    // Low byte first; an element is stored once its high byte is in
    task automatic load_a(input int nbytes);
        logic [7:0]  rx;
        logic [15:0] word;
        spi_select();
        spi_byte(cmd_load_a, rx);
        for (int k = 0; k < nbytes; k++) begin
            word = a_src[k/2];
            spi_byte(k[0] ? word[15:8] : word[7:0], rx);
            if (k[0]) begin
                a_model[k/2] = word;
            end
        end
        spi_deselect();
    endtask

    task automatic load_b();
        logic [7:0] rx;
        spi_select();
        spi_byte(cmd_load_b, rx);
        for (int k = 0; k < nn; k++) begin
            spi_byte(b_src[k], rx);
            b_model[k] = b_src[k];
        end
        spi_deselect();
    endtask

    task automatic read_status(input logic [7:0] exp);
        logic [7:0] rx;
        logic [7:0] st;
        spi_select();
        spi_byte(cmd_status, rx);
        spi_byte(8'h00, st);
        spi_deselect();
        check_value("status", {24'd0, st}, {24'd0, exp});
    endtask

    task automatic run_compute();
        int waited;
        send_command(cmd_start);
        waited = 0;
        while (!irq && waited < 20*n) begin
            wait_clk(1);
            waited++;
        end
        if (!irq) begin
            $display("Timed out waiting for irq after START");
            $display("SOME TESTS FAILED");
            $fatal(1, "no interrupt");
        end
    endtask

    task automatic read_results();
        logic [7:0]  rx;
        logic [31:0] word;
        spi_select();
        spi_byte(cmd_read_res, rx);
        for (int e = 0; e < nn; e++) begin
            for (int k = 0; k < 4; k++) begin
                spi_byte(8'h00, rx);
                word[k*8 +: 8] = rx;
                // irq clears with the first result byte
                if (e == 0 && k == 0) begin
                    check_value("irq", {31'd0, irq}, 32'd0);
                end
            end
            check_value($sformatf("c[%0d]", e), word, c_exp[e]);
        end
        spi_deselect();
    endtask

    function automatic logic [31:0] model_product(input int idx);
        logic [31:0] sum;
        int          i;
        int          j;
        sum = 32'd0;
        i = idx / n;
        j = idx % n;
        for (int k = 0; k < n; k++) begin
            sum += 32'(a_model[i*n + k]) * 32'(b_model[k*n + j]);
        end
        return sum;
    endfunction

    // ====================
    // Main sequence
    // ====================
    initial begin
        clk    = 1'b0;
        rst_n  = 1'b0;
        sclk   = 1'b0;
        cs_n   = 1'b1;
        mosi   = 1'b0;
        errors = 0;
        for (int e = 0; e < nn; e++) begin
            a_model[e] = 16'h0000;
            b_model[e] = 8'h00;
        end
        $readmemh("verif/systolic_vectors.txt", vec_mem);
        wait_clk(3);
        rst_n = 1'b1;
        wait_clk(2);

        check_value("irq", {31'd0, irq}, 32'd0);
        read_status(8'h00);

        for (int t = 0; t < num_tests; t++) begin
            unpack_vector(t);
            load_a(2*nn);
            load_b();
            run_compute();
            read_status(8'h08);
            read_results();
            check_value("irq", {31'd0, irq}, 32'd0);
            read_status(8'h00);
        end

        // LOAD_A cut short after two elements and a stray low byte
        unpack_vector(0);
        load_a(5);
        for (int e = 0; e < nn; e++) begin
            c_exp[e] = model_product(e);
        end
        run_compute();
        read_status(8'h08);
        read_results();
        read_status(8'h00);

        // Unknown command leaves everything alone
        send_unknown(8'hA5);
        read_status(8'h00);
        run_compute();
        read_results();

        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/systolic_vectors.txt ====
// Each test: 16 A words, then 16 B words, then 16 expected C words
// Hex, row-major; A is 16 bit, B is 8 bit, C is 32 bit
// Test 0: diagonal A
1234 0000 0000 0000 0000 ABCD 0000 0000 0000 0000 00FF 0000 0000 0000 0000 8001
01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0F 10
00001234 00002468 0000369C 000048D0 00035B01 000406CE 0004B29B 00055E68
000008F7 000009F6 00000AF5 00000BF4 0006800D 0007000E 0007800F 00080010
// Test 1: counting matrices
0001 0002 0003 0004 0005 0006 0007 0008 0009 000A 000B 000C 000D 000E 000F 0010
01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0F 10
0000005A 00000064 0000006E 00000078 000000CA 000000E4 000000FE 00000118
0000013A 00000164 0000018E 000001B8 000001AA 000001E4 0000021E 00000258
// Test 2: all elements at their maximum
FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF
03FBFC04 03FBFC04 03FBFC04 03FBFC04 03FBFC04 03FBFC04 03FBFC04 03FBFC04
03FBFC04 03FBFC04 03FBFC04 03FBFC04 03FBFC04 03FBFC04 03FBFC04 03FBFC04

// ==== tb.f ====
verilog/systolic_pkg.sv
verilog/spi_target.sv
verilog/mac_pe.sv
verilog/systolic_array.sv
verilog/spi_command_controller.sv
verilog/systolic_spi_top.sv
verif/systolic_spi_sva.sv
verif/tb_systolic_spi.sv

// ==== Makefile ====
# Verilator build and run for the SPI matrix-multiply testbench

VERILATOR ?= verilator
TOP       ?= tb_systolic_spi
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= SOME TESTS FAILED
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Result: failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Result: run ended early"; exit 1; fi
	@echo "Result: pass"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
